// ==== src/fe_consts.svh ====
`ifndef FE_CONSTS_SVH
`define FE_CONSTS_SVH

// hardware threads sharing the decoder
`define FE_THREADS 2

// per-thread instruction queue
`define FE_QDEPTH 8
`define FE_QPTR_W 3

// instruction fields
`define FE_REG_W 6
`define FE_OP_W 4

`endif

// ==== src/fe_pkg.sv ====
`include "fe_consts.svh"

package fe_pkg;

  // codes 10..15 are unassigned and decode as nop
  typedef enum logic [`FE_OP_W-1:0] {
    op_nop   = 4'd0,
    op_add   = 4'd1,
    op_sub   = 4'd2,
    op_and   = 4'd3,
    op_or    = 4'd4,
    op_shl   = 4'd5,
    op_mul   = 4'd6,
    op_load  = 4'd7,
    op_store = 4'd8,
    op_jump  = 4'd9
  } op_e;

  // execution port class
  typedef enum logic [1:0] {
    port_alu  = 2'd0,
    port_mul  = 2'd1,
    port_mem  = 2'd2,
    port_jump = 2'd3
  } port_e;

  typedef struct packed {
    op_e                 opcode;
    logic [`FE_REG_W-1:0] rt;
    logic [`FE_REG_W-1:0] ra;
    logic [`FE_REG_W-1:0] rb;
  } instr_t;

  // fill from the fetch side, tagged with its thread
  typedef struct packed {
    logic   thread;
    instr_t instr;
  } fill_t;

  typedef struct packed {
    logic                 thread;
    op_e                  op;
    port_e                port;
    logic [`FE_REG_W-1:0] rt;
    logic                 rt_use;
    logic [`FE_REG_W-1:0] ra;
    logic [`FE_REG_W-1:0] rb;
  } issue_t;

endpackage

// ==== src/fill_router.sv ====
`timescale 1ns/1ps
`include "fe_consts.svh"

module fill_router import fe_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   fill_en,
  input  fill_t                  fill,
  input  logic                   except,
  input  logic                   except_thread,
  output logic [`FE_THREADS-1:0] wr_en,
  output instr_t                 wr_data
);

  logic keep;

  // a fill racing an exception on its own thread is dead already
  assign keep = fill_en && !(except && (except_thread == fill.thread));

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_en <= '0;
    end else begin
      wr_en <= '0;
      if (keep) begin
        wr_en[fill.thread] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    wr_data <= fill.instr;
  end

endmodule

// ==== src/thread_queue.sv ====
`timescale 1ns/1ps
`include "fe_consts.svh"

module thread_queue import fe_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   wr_en,
  input  instr_t wr_data,
  input  logic   pop,
  input  logic   flush,
  output instr_t head,
  output logic   not_empty,
  output logic   full
);

  instr_t               mem [`FE_QDEPTH];
  logic [`FE_QPTR_W-1:0] rd_ptr;
  logic [`FE_QPTR_W-1:0] wr_ptr;
  logic [`FE_QPTR_W:0]   count;
  logic                  do_wr;
  logic                  do_pop;

  assign do_wr  = wr_en;
  assign do_pop = pop && not_empty;

  assign head      = mem[rd_ptr];
  assign not_empty = (count != '0);
  assign full      = (count == `FE_QDEPTH);

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // flush wins over a write or pop in the same cycle
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== src/issue_select.sv ====
`timescale 1ns/1ps
`include "fe_consts.svh"

module issue_select import fe_pkg::*; (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           stall,
  input  logic                           except,
  input  logic                           except_thread,
  input  instr_t [`FE_THREADS-1:0]       head,
  input  logic [`FE_THREADS-1:0]         not_empty,
  output logic [`FE_THREADS-1:0]         pop,
  output logic                           issue_en,
  output issue_t                         issue
);

  logic sel;
  logic sel_hit;

  function automatic issue_t decode(input instr_t w, input logic t);
    issue_t r;
    r.thread = t;
    r.rt     = w.rt;
    r.ra     = w.ra;
    r.rb     = w.rb;
    r.op     = w.opcode;
    r.port   = port_alu;
    r.rt_use = 1'b1;
    case (w.opcode)
      op_add, op_sub, op_and, op_or, op_shl: begin
        r.port = port_alu;
      end
      op_mul: begin
        r.port = port_mul;
      end
      op_load: begin
        r.port = port_mem;
      end
      op_store: begin
        r.port   = port_mem;
        r.rt_use = 1'b0;
      end
      op_jump: begin
        r.port   = port_jump;
        r.rt_use = 1'b0;
      end
      default: begin
        // unassigned codes fall back to nop
        r.op     = op_nop;
        r.rt_use = 1'b0;
      end
    endcase
    return r;
  endfunction

  // selected thread loses its slot while it is being flushed
  assign sel_hit = !stall && not_empty[sel] && !(except && (except_thread == sel));

  always_comb begin
    pop      = '0;
    pop[sel] = sel_hit;
  end

  // prefer the only thread with work, steer off an excepting one, else alternate
  always_ff @(posedge clk) begin
    if (rst) begin
      sel <= 1'b0;
    end else if (!stall) begin
      if (not_empty[0] && (!not_empty[1] || (except && except_thread))) begin
        sel <= 1'b0;
      end else if (not_empty[1] && (!not_empty[0] || (except && !except_thread))) begin
        sel <= 1'b1;
      end else begin
        sel <= !sel;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      issue_en <= 1'b0;
    end else begin
      issue_en <= |pop;
    end
  end

  always_ff @(posedge clk) begin
    issue <= decode(head[sel], sel);
  end

endmodule

// ==== src/frontend_top.sv ====
`timescale 1ns/1ps
`include "fe_consts.svh"

module frontend_top import fe_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   fill_en,
  input  fill_t                  fill,
  input  logic                   stall,
  input  logic                   except,
  input  logic                   except_thread,
  output logic                   issue_en,
  output issue_t                 issue,
  output logic [`FE_THREADS-1:0] full
);

  logic [`FE_THREADS-1:0]   wr_en;
  instr_t                   wr_data;
  instr_t [`FE_THREADS-1:0] head;
  logic [`FE_THREADS-1:0]   not_empty;
  logic [`FE_THREADS-1:0]   pop;
  logic [`FE_THREADS-1:0]   flush;

  fill_router i_fill_router (
    .clk           (clk),
    .rst           (rst),
    .fill_en       (fill_en),
    .fill          (fill),
    .except        (except),
    .except_thread (except_thread),
    .wr_en         (wr_en),
    .wr_data       (wr_data)
  );

  for (genvar i = 0; i < `FE_THREADS; i++) begin : g_thread
    assign flush[i] = except && (except_thread == 1'(i));

    thread_queue i_thread_queue (
      .clk       (clk),
      .rst       (rst),
      .wr_en     (wr_en[i]),
      .wr_data   (wr_data),
      .pop       (pop[i]),
      .flush     (flush[i]),
      .head      (head[i]),
      .not_empty (not_empty[i]),
      .full      (full[i])
    );
  end

  issue_select i_issue_select (
    .clk           (clk),
    .rst           (rst),
    .stall         (stall),
    .except        (except),
    .except_thread (except_thread),
    .head          (head),
    .not_empty     (not_empty),
    .pop           (pop),
    .issue_en      (issue_en),
    .issue         (issue)
  );

endmodule

// ==== tests/frontend_checker.sv ====
`timescale 1ns/1ps
`include "fe_consts.svh"

module frontend_checker import fe_pkg::*; (
  input logic                   clk,
  input logic                   rst,
  input logic                   fill_en,
  input fill_t                  fill,
  input logic [`FE_THREADS-1:0] full,
  input logic [`FE_THREADS-1:0] pop,
  input logic                   issue_en,
  input issue_t                 issue
);

  // source must respect the full level of the owning thread
  a_no_fill_when_full: assert property (
    @(posedge clk) disable iff (rst) fill_en |-> !full[fill.thread]
  ) else $error("fill sent to a thread whose queue is full");

  // queues come out of reset empty, so the first cycle cannot pop
  a_quiet_after_reset: assert property (
    @(posedge clk) $fell(rst) |=> !issue_en
  ) else $error("issue_en high in the cycle right after reset");

  // issued thread popped one cycle earlier
  a_issue_from_pop: assert property (
    @(posedge clk) disable iff (rst)
      issue_en |-> (issue.thread ? $past(pop[1]) : $past(pop[0]))
  ) else $error("issue record from a thread that did not pop");

endmodule

bind frontend_top frontend_checker i_frontend_checker (
  .clk      (clk),
  .rst      (rst),
  .fill_en  (fill_en),
  .fill     (fill),
  .full     (full),
  .pop      (pop),
  .issue_en (issue_en),
  .issue    (issue)
);

// ==== tests/tb_frontend.sv ====
`timescale 1ns/1ps
`include "fe_consts.svh"

module tb_frontend import fe_pkg::*; ();

  localparam int STIM_CYCLES    = 3000;
  localparam int TIMEOUT_CYCLES = STIM_CYCLES + 64;
  localparam int REG_W          = `FE_REG_W;
  localparam int OP_W           = `FE_OP_W;

  logic                   clk;
  logic                   rst;
  logic                   fill_en;
  fill_t                  fill;
  logic                   stall;
  logic                   except;
  logic                   except_thread;
  logic                   issue_en;
  issue_t                 issue;
  logic [`FE_THREADS-1:0] full;

  logic [31:0] lfsr;
  int          cycle_count = 0;

  // reference model state, mirrors the registers of the DUT
  instr_t                 mq [`FE_THREADS][$];
  logic                   pend_valid;
  logic                   pend_thread;
  instr_t                 pend_word;
  logic                   m_sel;
  logic                   exp_en;
  issue_t                 exp_issue;
  logic [`FE_THREADS-1:0] exp_full;

  frontend_top i_frontend_top (
    .clk           (clk),
    .rst           (rst),
    .fill_en       (fill_en),
    .fill          (fill),
    .stall         (stall),
    .except        (except),
    .except_thread (except_thread),
    .issue_en      (issue_en),
    .issue         (issue),
    .full          (full)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      abort_run("timeout: the run did not finish within its cycle budget");
    end
  end

  // taps 32 22 2 1
  function automatic logic [31:0] draw(input int nbits);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic issue_t expected_issue(input instr_t w, input logic t);
    issue_t e;
    e.thread = t;
    e.rt     = w.rt;
    e.ra     = w.ra;
    e.rb     = w.rb;
    e.op     = (w.opcode <= op_jump) ? w.opcode : op_nop;
    if (e.op == op_mul) begin
      e.port = port_mul;
    end else if (e.op == op_load || e.op == op_store) begin
      e.port = port_mem;
    end else if (e.op == op_jump) begin
      e.port = port_jump;
    end else begin
      e.port = port_alu;
    end
    e.rt_use = !(e.op == op_store || e.op == op_jump || e.op == op_nop);
    return e;
  endfunction

  task automatic check_issue(input string name, input logic want_en, input issue_t want,
                             input logic got_en, input issue_t got);
    if (got_en !== want_en) begin
      abort_run($sformatf("Error %s: issue_en expected %b actual %b", name, want_en, got_en));
    end else if (want_en && (got !== want)) begin
      abort_run($sformatf("Error %s: issue expected %h actual %h", name, want, got));
    end
  endtask

  task automatic check_full(input string name, input logic [`FE_THREADS-1:0] want,
                            input logic [`FE_THREADS-1:0] got);
    if (got !== want) begin
      abort_run($sformatf("Error %s: full expected %b actual %b", name, want, got));
    end
  endtask

  task automatic reset_model();
    for (int t = 0; t < `FE_THREADS; t++) begin
      mq[t].delete();
    end
    pend_valid  = 1'b0;
    pend_thread = 1'b0;
    pend_word   = '0;
    m_sel       = 1'b0;
    exp_en      = 1'b0;
    exp_issue   = '0;
    exp_full    = '0;
  endtask

  // counts the word still in the router so the queue never overfills
  function automatic logic has_room(input logic t);
    int used;
    used = mq[t].size() + ((pend_valid && pend_thread == t) ? 1 : 0);
    return used < `FE_QDEPTH;
  endfunction

  function automatic logic model_busy();
    logic busy;
    busy = pend_valid || exp_en;
    for (int t = 0; t < `FE_THREADS; t++) begin
      busy = busy || (mq[t].size() != 0);
    end
    return busy;
  endfunction

  task automatic drive_random();
    fill_t f;
    logic  want_fill;
    stall         = (draw(3) == 0);
    except        = (draw(8) < 6);
    except_thread = 1'(draw(1));
    want_fill     = (draw(3) != 0);
    f.thread       = 1'(draw(1));
    f.instr.opcode = op_e'(OP_W'(draw(OP_W)));
    f.instr.rt     = REG_W'(draw(REG_W));
    f.instr.ra     = REG_W'(draw(REG_W));
    f.instr.rb     = REG_W'(draw(REG_W));
    fill_en = want_fill && has_room(f.thread);
    fill    = f;
  endtask

  task automatic drive_idle();
    fill_en       = 1'b0;
    fill          = '0;
    stall         = 1'b0;
    except        = 1'b0;
    except_thread = 1'b0;
  endtask

  // advance the model across the next rising edge
  task automatic step_model();
    logic [`FE_THREADS-1:0] ne;
    logic [`FE_THREADS-1:0] flush_v;
    logic                   popv;
    logic                   old_sel;
    for (int t = 0; t < `FE_THREADS; t++) begin
      ne[t]      = (mq[t].size() != 0);
      flush_v[t] = except && (except_thread == 1'(t));
    end
    old_sel = m_sel;
    popv    = !stall && ne[old_sel] && !flush_v[old_sel];
    exp_en  = popv;
    if (popv) begin
      exp_issue = expected_issue(mq[old_sel][0], old_sel);
    end
    if (!stall) begin
      if (ne[0] && (!ne[1] || flush_v[1])) begin
        m_sel = 1'b0;
      end else if (ne[1] && (!ne[0] || flush_v[0])) begin
        m_sel = 1'b1;
      end else begin
        m_sel = !old_sel;
      end
    end
    for (int t = 0; t < `FE_THREADS; t++) begin
      if (flush_v[t]) begin
        mq[t].delete();
      end else begin
        if (popv && old_sel == 1'(t)) begin
          void'(mq[t].pop_front());
        end
        if (pend_valid && pend_thread == 1'(t)) begin
          mq[t].push_back(pend_word);
        end
      end
    end
    pend_valid  = fill_en && !flush_v[fill.thread];
    pend_thread = fill.thread;
    pend_word   = fill.instr;
    for (int t = 0; t < `FE_THREADS; t++) begin
      exp_full[t] = (mq[t].size() == `FE_QDEPTH);
    end
  endtask

  initial begin
    lfsr = 32'h17e8;
    rst  = 1'b1;
    drive_idle();
    reset_model();
    repeat (4) begin
      @(negedge clk);
      check_issue("reset", 1'b0, exp_issue, issue_en, issue);
      check_full("reset", '0, full);
    end
    rst = 1'b0;
    for (int cyc = 0; cyc < STIM_CYCLES; cyc++) begin
      drive_random();
      step_model();
      @(negedge clk);
      check_issue($sformatf("random cycle %0d", cyc), exp_en, exp_issue, issue_en, issue);
      check_full($sformatf("random cycle %0d", cyc), exp_full, full);
    end
    // let both queues run dry
    drive_idle();
    while (model_busy()) begin
      step_model();
      @(negedge clk);
      check_issue("drain", exp_en, exp_issue, issue_en, issue);
      check_full("drain", exp_full, full);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+src
src/fe_pkg.sv
src/fill_router.sv
src/thread_queue.sv
src/issue_select.sv
src/frontend_top.sv
tests/frontend_checker.sv
tests/tb_frontend.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_frontend
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard src/*.sv src/*.svh tests/*.sv)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
